//--- psuS3SwCtrl.f
+incdir+common
common/psuSeqPkg.sv
src/delayTimer.sv
sequencer/powerStateFsm.sv
sequencer/dimmSwitchCtrl.sv
src/railFaultMonitor.sv
src/psuS3SwCtrl.sv
verification/tbClkGen.sv
verification/psuS3SwCtrl_chk.sv
verification/tbPsuS3SwCtrl.sv

//--- runSim.sh
#!/bin/sh
# compile the power sequencer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   --top-module tbPsuS3SwCtrl -f psuS3SwCtrl.f -o simPsuS3SwCtrl

# the simulator status alone is not trusted, the pass line decides
result=$(./obj_dir/simPsuS3SwCtrl 2>&1) || true
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "^STATUS: PASS$"

//--- verification/tbPsuS3SwCtrl.sv
/* power sequencer testbench
   drives the sequencer through a table of input levels and checks every output */

`timescale 1ns/1ps
`include "psuSeq_settings.svh"

module tbPsuS3SwCtrl;

   localparam int waitLimit  = `PSU_T2_CYCLES + 200;   // longest hand-over plus the rail steps
   localparam int resetLimit = 50;

   logic        iClk;
   logic        iRst_n;
   logic        iEnaSw;
   logic        iEnaMain;
   logic        iSlpS3;
   logic        iSlpS5;
   logic        iDimm12VCpsS5_n;
   logic        iPsPwrOk;
   logic        iPwrGdP3V3;
   logic        iAdrEna;
   logic        iAcRemoval;
   logic        oPsuEna;
   logic        oP5VEna;
   logic        oClkDevEna;
   logic        oFault;
   logic [2:0]  oFaultCode;
   logic        oDone;
   logic        oAuxSwEna;
   logic        oS3SwP12vStbyEna;
   logic        oS3SwP12vMainEna;
   logic [10:0] outWord;                       // all outputs packed in table order

   logic [8:0]  stimQ[$];                      // input levels of each row
   logic [10:0] wantQ[$];                      // expected output word of each row
   string       nameQ[$];
   int          errorCount = 0;
   int          rowsPassed = 0;
   bit          aborted    = 1'b0;             // set when a wait runs out

   tbClkGen #(.periodNs(8), .resetCycles(2)) uClkGen (.clk(iClk), .rst_n(iRst_n));

   psuS3SwCtrl u_dut
   (
      .iClk(iClk), .iRst_n(iRst_n), .iEnaSw(iEnaSw), .iEnaMain(iEnaMain),
      .iSlpS3(iSlpS3), .iSlpS5(iSlpS5), .iDimm12VCpsS5_n(iDimm12VCpsS5_n),
      .iPsPwrOk(iPsPwrOk), .iPwrGdP3V3(iPwrGdP3V3), .iAdrEna(iAdrEna),
      .iAcRemoval(iAcRemoval), .oPsuEna(oPsuEna), .oP5VEna(oP5VEna),
      .oClkDevEna(oClkDevEna), .oFault(oFault), .oFaultCode(oFaultCode), .oDone(oDone),
      .oAuxSwEna(oAuxSwEna), .oS3SwP12vStbyEna(oS3SwP12vStbyEna),
      .oS3SwP12vMainEna(oS3SwP12vMainEna)
   );

   bind psuS3SwCtrl psuS3SwCtrl_chk uChk
   (
      .iClk(iClk), .iRst_n(iRst_n), .oPsuEna(oPsuEna), .oP5VEna(oP5VEna),
      .oClkDevEna(oClkDevEna), .oFault(oFault), .oFaultCode(oFaultCode),
      .oS3SwP12vMainEna(oS3SwP12vMainEna)
   );

   assign outWord = {oPsuEna, oP5VEna, oClkDevEna, oDone, oAuxSwEna, oS3SwP12vStbyEna,
                     oS3SwP12vMainEna, oFault, oFaultCode};

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want)
      begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
         errorCount++;
      end
   endtask

   task automatic addRow(input logic [8:0] stim, input logic [10:0] want, input string name);
      stimQ.push_back(stim);
      wantQ.push_back(want);
      nameQ.push_back(name);
   endtask

   // polls on the falling edge so that a rising edge passes before the first look
   task automatic waitForWord(input logic [10:0] want, input logic [10:0] hold, output bit seen,
                              output bit moved);
      int n;
      n     = 0;
      seen  = 1'b0;
      moved = 1'b0;
      while (!seen && n < waitLimit)
      begin
         @(negedge iClk);
         n++;
         if (((outWord ^ want) & hold) !== 11'd0)
            moved = 1'b1;                      // a bit left the level it shares with the last row
         seen = (outWord === want);
      end
   endtask

   task automatic checkOutputs(input logic [10:0] want);
      checkValue("oPsuEna", 32'(oPsuEna), 32'(want[10]));
      checkValue("oP5VEna", 32'(oP5VEna), 32'(want[9]));
      checkValue("oClkDevEna", 32'(oClkDevEna), 32'(want[8]));
      checkValue("oDone", 32'(oDone), 32'(want[7]));
      checkValue("oAuxSwEna", 32'(oAuxSwEna), 32'(want[6]));
      checkValue("oS3SwP12vStbyEna", 32'(oS3SwP12vStbyEna), 32'(want[5]));
      checkValue("oS3SwP12vMainEna", 32'(oS3SwP12vMainEna), 32'(want[4]));
      checkValue("oFault", 32'(oFault), 32'(want[3]));
      checkValue("oFaultCode", 32'(oFaultCode), 32'(want[2:0]));
   endtask

   task automatic loadTable();
      // input bits enaSw enaMain slpS3 slpS5 dimm12VCpsS5_n psPwrOk pwrGdP3V3 adrEna acRemoval
      // output bits psu p5v clkDev done auxSw stbySw mainSw fault faultCode
      addRow(9'b0_0_1_1_1_0_0_0_0, 11'b0_0_0_0_0_0_0_0_000, "idle after reset");
      addRow(9'b1_0_1_1_1_0_0_0_0, 11'b0_0_0_0_0_0_0_0_000, "enabled in S5");
      addRow(9'b1_1_0_0_1_0_0_0_0, 11'b1_0_0_0_0_0_0_0_000, "cold power-up, PSU on");
      addRow(9'b1_1_0_0_1_1_0_0_0, 11'b1_1_0_0_1_0_0_0_000, "PSU good, P5V on");
      addRow(9'b1_1_0_0_1_1_1_0_0, 11'b1_1_1_1_1_0_1_0_000, "P3V3 good, S0 on main");
      addRow(9'b1_0_1_0_1_1_1_0_0, 11'b1_0_0_1_1_0_1_0_000, "main off toward S3");
      addRow(9'b1_0_1_0_1_1_0_0_0, 11'b1_0_0_1_1_1_1_0_000, "S3 hold, both feeds");
      addRow(9'b1_0_1_0_1_1_0_0_0, 11'b0_0_0_0_0_1_0_0_000, "S3 after T2, standby only");
      addRow(9'b1_1_0_0_1_1_0_0_0, 11'b1_1_0_0_1_1_0_0_000, "resume from S3");
      addRow(9'b1_1_0_0_1_1_1_0_0, 11'b1_1_1_1_1_1_1_0_000, "S0 hold, both feeds");
      addRow(9'b1_1_0_0_1_1_1_0_0, 11'b1_1_1_1_1_0_1_0_000, "S0 after T1, main only");
      addRow(9'b1_0_0_1_0_1_1_0_0, 11'b1_0_0_1_1_0_1_0_000, "jumper fitted, main off");
      addRow(9'b1_0_0_1_0_1_0_0_0, 11'b1_0_0_1_1_1_1_0_000, "S3 hold toward S5p");
      addRow(9'b1_0_0_1_0_1_0_0_0, 11'b0_0_0_0_0_1_0_0_000, "S5p keeps standby");
      addRow(9'b1_1_0_0_0_1_0_0_0, 11'b1_1_0_0_1_1_0_0_000, "power-up from S5p");
      addRow(9'b1_1_0_0_0_1_1_0_0, 11'b1_1_1_1_1_1_1_0_000, "S0 hold from S5p");
      addRow(9'b1_0_0_1_0_1_1_0_1, 11'b0_0_0_0_0_0_0_0_000, "AC removal, S5 all off");
      addRow(9'b1_1_0_0_1_1_1_0_0, 11'b1_1_1_1_1_0_1_0_000, "power-up to S0 again");
      addRow(9'b1_1_0_0_1_1_1_1_0, 11'b1_1_1_1_1_0_1_0_000, "ADR enabled in S0");
      addRow(9'b1_1_0_0_1_0_1_1_0, 11'b1_1_1_1_1_0_1_0_000, "PSU good lost under ADR");
      addRow(9'b1_1_0_0_1_0_1_0_0, 11'b1_1_1_1_1_0_1_1_001, "PSU good lost, no ADR");
      addRow(9'b1_1_0_0_1_1_0_0_0, 11'b1_1_1_1_1_0_1_1_010, "P3V3 lost under good PSU");
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial
   begin
      int          i;
      int          n;
      int          errBefore;
      bit          seen;
      bit          moved;
      logic [10:0] prevWant;                   // expected word of the row before
      {iEnaSw, iEnaMain, iSlpS3, iSlpS5, iDimm12VCpsS5_n, iPsPwrOk, iPwrGdP3V3, iAdrEna,
       iAcRemoval} = 9'b0_0_1_1_1_0_0_0_0;   // box in S5 with no jumper and the rails down
      prevWant = 11'd0;
      loadTable();
      @(negedge iClk);
      checkValue("output word in reset", 32'(outWord), 32'd0);
      n = 0;
      while (!iRst_n && n < resetLimit)
      begin
         @(negedge iClk);
         n++;
      end
      if (!iRst_n)
      begin
         $display("reset was never released by the clock generator");
         errorCount++;
         aborted = 1'b1;
      end
      i = 0;
      while (!aborted && i < stimQ.size())
      begin
         errBefore = errorCount;
         {iEnaSw, iEnaMain, iSlpS3, iSlpS5, iDimm12VCpsS5_n, iPsPwrOk, iPwrGdP3V3, iAdrEna,
          iAcRemoval} = stimQ[i];            // applied on the falling edge
         waitForWord(wantQ[i], ~(prevWant ^ wantQ[i]), seen, moved);
         if (!seen)
         begin
            $display("row %0d (%s): timed out waiting for the expected outputs", i, nameQ[i]);
            errorCount++;
            aborted = 1'b1;                  // later rows depend on this state
         end
         if (moved)
         begin
            $display("row %0d (%s): an output left its steady level while waiting", i, nameQ[i]);
            errorCount++;
         end
         checkOutputs(wantQ[i]);
         if (errorCount == errBefore)
         begin
            $display("row %0d (%s): ok", i, nameQ[i]);
            rowsPassed++;
         end
         else
            $display("row %0d (%s): failed", i, nameQ[i]);
         prevWant = wantQ[i];
         i++;
      end
      $display("rows run %0d, rows passed %0d, errors %0d", i, rowsPassed, errorCount);
      if (errorCount == 0 && !aborted)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- verification/psuS3SwCtrl_chk.sv
/* sequencer output checks
   concurrent assertions bound to the top level of the power sequencer */

`timescale 1ns/1ps

module psuS3SwCtrl_chk
(
   input logic       iClk,
   input logic       iRst_n,
   input logic       oPsuEna,
   input logic       oP5VEna,
   input logic       oClkDevEna,
   input logic       oFault,
   input logic [2:0] oFaultCode,
   input logic       oS3SwP12vMainEna
);

   // the clock generator only runs on top of the P5V rail
   aClkNeedsP5v: assert property (@(posedge iClk) disable iff (!iRst_n)
      oClkDevEna |-> oP5VEna)
      else $error("clock generator enabled while P5V enable is low");

   // the main feed of the DIMM switch comes from the PSU 12 V
   aMainSwNeedsPsu: assert property (@(posedge iClk) disable iff (!iRst_n)
      oS3SwP12vMainEna |-> oPsuEna)
      else $error("DIMM main switch on while PSU enable is low");

   aFaultHasCode: assert property (@(posedge iClk) disable iff (!iRst_n)
      oFault == (oFaultCode != 3'd0))
      else $error("fault flag and fault code disagree");   // flag and code are set together

endmodule

//--- verification/tbClkGen.sv
/* testbench clock and reset
   free running clock and an active low reset held for a set number of cycles */

`timescale 1ns/1ps

module tbClkGen
#(
   parameter int periodNs    = 8,              // clock period in ns
   parameter int resetCycles = 2               // rising edges seen with reset held
)
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(periodNs / 2.0) clk = ~clk;    // even duty cycle
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;                            // released away from the active edge
   end

endmodule

//--- src/psuS3SwCtrl.sv
/* PSU, main VR and DIMM S3 switch control
   connects the state sequencer, the DIMM switch control, the fault monitor and the hand-over timers */

`timescale 1ns/1ps
`include "psuSeq_settings.svh"

module psuS3SwCtrl
(
   input  logic       iClk,
   input  logic       iRst_n,
   input  logic       iEnaSw,                  // master lets the block run
   input  logic       iEnaMain,                // master asks for the main rails
   input  logic       iSlpS3,
   input  logic       iSlpS5,
   input  logic       iDimm12VCpsS5_n,         // keep-alive jumper, active low
   input  logic       iPsPwrOk,
   input  logic       iPwrGdP3V3,
   input  logic       iAdrEna,
   input  logic       iAcRemoval,              // AC lost, DIMM 12 V must go down in S5
   output logic       oPsuEna,
   output logic       oP5VEna,
   output logic       oClkDevEna,
   output logic       oFault,
   output logic [2:0] oFaultCode,
   output logic       oDone,
   output logic       oAuxSwEna,
   output logic       oS3SwP12vStbyEna,
   output logic       oS3SwP12vMainEna
);

   import psuSeqPkg::*;

   psuState_e state;                             // current sequencer state
   logic      railFail;
   logic      keepStby;
   logic      startT1;
   logic      startT2;
   logic      doneT1;
   logic      doneT2;

   powerStateFsm uFsm
   (
      .iClk(iClk), .iRst_n(iRst_n), .iEnaSw(iEnaSw), .iEnaMain(iEnaMain),
      .iSlpS3(iSlpS3), .iSlpS5(iSlpS5), .iDimm12VCpsS5_n(iDimm12VCpsS5_n),
      .iAcRemoval(iAcRemoval), .iPsPwrOk(iPsPwrOk), .iPwrGdP3V3(iPwrGdP3V3),
      .railFail(railFail), .keepStby(keepStby), .doneT1(doneT1), .doneT2(doneT2),
      .state(state), .oPsuEna(oPsuEna), .oP5VEna(oP5VEna), .oClkDevEna(oClkDevEna),
      .oDone(oDone)
   );

   dimmSwitchCtrl uDimmSw
   (
      .iClk(iClk), .iRst_n(iRst_n), .iDimm12VCpsS5_n(iDimm12VCpsS5_n), .state(state),
      .keepStby(keepStby), .startT1(startT1), .startT2(startT2), .oAuxSwEna(oAuxSwEna),
      .oS3SwP12vStbyEna(oS3SwP12vStbyEna), .oS3SwP12vMainEna(oS3SwP12vMainEna)
   );

   railFaultMonitor uFaultMon
   (
      .iClk(iClk), .iRst_n(iRst_n), .iAdrEna(iAdrEna), .iPsPwrOk(iPsPwrOk),
      .iPwrGdP3V3(iPwrGdP3V3), .state(state), .railFail(railFail), .oFault(oFault),
      .oFaultCode(oFaultCode)
   );

   // standby to main overlap on the power-up path
   delayTimer #(.cycles(`PSU_T1_CYCLES)) uT1
   (
      .iClk(iClk), .iRst_n(iRst_n), .start(startT1), .done(doneT1)
   );

   // main to standby overlap on the power-down path
   delayTimer #(.cycles(`PSU_T2_CYCLES)) uT2
   (
      .iClk(iClk), .iRst_n(iRst_n), .start(startT2), .done(doneT2)
   );

endmodule

//--- src/railFaultMonitor.sv
/* rail fault monitor
   watches PSU and main VR power good against the latched ADR enable and reports a fault code */

`timescale 1ns/1ps

module railFaultMonitor
(
   input  logic                  iClk,
   input  logic                  iRst_n,
   input  logic                  iAdrEna,
   input  logic                  iPsPwrOk,
   input  logic                  iPwrGdP3V3,
   input  psuSeqPkg::psuState_e  state,
   output logic                  railFail,      // fault condition in this cycle
   output logic                  oFault,
   output psuSeqPkg::faultCode_e oFaultCode
);

   import psuSeqPkg::*;

   logic adrLatch;                               // ADR enable as seen while main was up
   logic psuFail;                                // PSU good dropped without ADR
   logic vrFail;                                 // P3V3 main good dropped under a good PSU

   // ADR enable follows the input while main runs and is kept for the power-down
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
         adrLatch <= 1'b0;
      else if (state inside {p5v, s0hold, s0})
         adrLatch <= iAdrEna;
      else if (state inside {init, s5, s5p})
         adrLatch <= 1'b0;
   end

   assign psuFail  = (state inside {p5v, s3hold, s0hold, s0}) && !iPsPwrOk && !adrLatch;
   assign vrFail   = (state inside {s0hold, s0}) && !iPwrGdP3V3 && iPsPwrOk;
   assign railFail = psuFail || vrFail;

   //////////////////////////////////////////////////
   // fault report
   //////////////////////////////////////////////////
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         oFault     <= 1'b0;
         oFaultCode <= none;
      end
      else if (psuFail)
      begin
         oFault     <= 1'b1;
         oFaultCode <= psuPwrOk;
      end
      else if (vrFail)
      begin
         oFault     <= 1'b1;
         oFaultCode <= mainVr;
      end
      else if (!(state inside {s0, s3hold}))
      begin
         oFault     <= 1'b0;                     // sticky only while the rails are still up
         oFaultCode <= none;
      end
   end

endmodule

//--- sequencer/dimmSwitchCtrl.sv
/* DIMM 12 V switch control
   keeps the S3/S5p history and selects standby or main feed for the DIMM switch */

`timescale 1ns/1ps

module dimmSwitchCtrl
(
   input  logic                 iClk,
   input  logic                 iRst_n,
   input  logic                 iDimm12VCpsS5_n,  // low when the keep-alive jumper is fitted
   input  psuSeqPkg::psuState_e state,
   output logic                 keepStby,         // DIMMs already powered from standby
   output logic                 startT1,
   output logic                 startT2,
   output logic                 oAuxSwEna,
   output logic                 oS3SwP12vStbyEna,
   output logic                 oS3SwP12vMainEna
);

   import psuSeqPkg::*;

   logic s3Flag;                                 // last low power state was S3
   logic s5pFlag;                                // last low power state was S5p

   // history flags, they tell power-up whether the DIMMs are still live
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         s3Flag  <= 1'b0;
         s5pFlag <= 1'b0;
      end
      else
      begin
         if (state inside {s3, s3hold})
            s3Flag <= 1'b1;
         else if (state inside {init, s5, s5p, s0hold, s0})
            s3Flag <= 1'b0;                      // cleared once main has taken over
         if (state == s5p)
            s5pFlag <= 1'b1;
         else if (state inside {init, s5, s3, s0hold})
            s5pFlag <= 1'b0;
      end
   end

   assign keepStby = s3Flag || (s5pFlag && !iDimm12VCpsS5_n);

   //////////////////////////////////////////////////
   // switch enables
   //////////////////////////////////////////////////
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         oAuxSwEna        <= 1'b0;
         oS3SwP12vStbyEna <= 1'b0;
         oS3SwP12vMainEna <= 1'b0;
      end
      else
      begin
         oAuxSwEna        <= state inside {p5v, s0hold, s0, s0down, s3hold};
         oS3SwP12vStbyEna <= (state inside {s5p, s3, s0hold, s3hold}) ||
                             ((state inside {psu, p5v}) && keepStby); // stays live through power-up
         oS3SwP12vMainEna <= state inside {s0hold, s0, s0down, s3hold}; // both feeds overlap in holds
      end
   end

   assign startT1 = (state == s0hold);          // standby to main overlap
   assign startT2 = (state == s3hold);          // main to standby overlap

endmodule

//--- sequencer/powerStateFsm.sv
/* power state sequencer
   steps the main rails through S5, S3 and S0 and drives the rail, clock and done enables */

`timescale 1ns/1ps

module powerStateFsm
(
   input  logic                 iClk,
   input  logic                 iRst_n,
   input  logic                 iEnaSw,           // master lets the block run
   input  logic                 iEnaMain,         // master asks for the main rails
   input  logic                 iSlpS3,
   input  logic                 iSlpS5,
   input  logic                 iDimm12VCpsS5_n,  // low when the keep-alive jumper is fitted
   input  logic                 iAcRemoval,
   input  logic                 iPsPwrOk,
   input  logic                 iPwrGdP3V3,
   input  logic                 railFail,         // rail fault seen in this cycle
   input  logic                 keepStby,         // DIMM 12 V is live from standby
   input  logic                 doneT1,
   input  logic                 doneT2,
   output psuSeqPkg::psuState_e state,
   output logic                 oPsuEna,
   output logic                 oP5VEna,
   output logic                 oClkDevEna,       // external clock generator enable
   output logic                 oDone
);

   import psuSeqPkg::*;

   psuState_e nextState;
   logic      mainOff;                           // master has taken the main request away
   logic      keepS5p;                           // S5 entry must keep DIMM 12 V alive

   assign mainOff = !iEnaMain;
   assign keepS5p = !iDimm12VCpsS5_n && !iAcRemoval; // jumper fitted and AC still present

   //////////////////////////////////////////////////
   // state register
   //////////////////////////////////////////////////
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
         state <= init;
      else
         state <= nextState;
   end

   //////////////////////////////////////////////////
   // next state
   //////////////////////////////////////////////////
   always_comb
   begin
      nextState = state;                         // every state waits for its exit condition
      case (state)
         init:
            if (iEnaSw)
               nextState = s5;
         s5, s5p:
            if (!iSlpS5 && iEnaMain)
               nextState = psu;                  // straight to PSU, no detour through S3
         s3:
         begin
            if (!iSlpS5 && !iSlpS3 && iEnaMain)
               nextState = psu;
            else if (iSlpS5 && mainOff)
               nextState = iDimm12VCpsS5_n ? s5 : s5p;
         end
         psu:
         begin
            if (iEnaMain && iPsPwrOk)
               nextState = p5v;
            else if (mainOff)
               nextState = (iSlpS5 && keepS5p) ? s5p : s5;
         end
         p5v:
            if (iEnaMain && iPwrGdP3V3)
               nextState = keepStby ? s0hold : s0; // hand-over only if DIMMs run from standby
         s0hold:
         begin
            if (railFail)
               nextState = s0hold;               // a fault freezes the sequence
            else if (mainOff && iSlpS3)
               nextState = s3;
            else if (mainOff && iSlpS5)
               nextState = keepS5p ? s5p : s5;
            else if (iEnaMain && doneT1 && !iSlpS3 && !iSlpS5)
               nextState = s0;                   // standby can now be dropped
         end
         s0:
            if (!railFail && mainOff)
               nextState = s0down;
         s0down:
         begin
            if (mainOff && !iPwrGdP3V3 && iSlpS3 && !iSlpS5)
               nextState = s3hold;
            else if (mainOff && !iPwrGdP3V3 && iSlpS5)
               nextState = keepS5p ? s3hold : s5;
            else if (mainOff && !iSlpS5 && !iSlpS3)
               nextState = s5;                   // enable gone without any sleep request
         end
         s3hold:
         begin
            if (railFail)
               nextState = s3hold;
            else if (mainOff && iSlpS3 && doneT2)
               nextState = s3;
            else if (mainOff && iSlpS5 && iDimm12VCpsS5_n)
               nextState = s5;                   // no jumper, no need to wait for hand-over
            else if (mainOff && iSlpS5 && !iDimm12VCpsS5_n && doneT2)
               nextState = s5p;
         end
         default:
            nextState = init;
      endcase
   end

   //////////////////////////////////////////////////
   // registered enables
   //////////////////////////////////////////////////
   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
      begin
         oPsuEna    <= 1'b0;
         oP5VEna    <= 1'b0;
         oClkDevEna <= 1'b0;
         oDone      <= 1'b0;
      end
      else
      begin
         oPsuEna    <= state inside {psu, p5v, s0hold, s0, s0down, s3hold}; // 12 V main on
         oP5VEna    <= state inside {p5v, s0hold, s0};                      // P5V main VR
         oClkDevEna <= state inside {s0hold, s0};                           // rails good
         oDone      <= state inside {s0hold, s0, s0down, s3hold};
      end
   end

endmodule

//--- src/delayTimer.sv
/* delay timer
   counts while start is held and raises done after a set number of cycles */

`timescale 1ns/1ps
`include "psuSeq_settings.svh"

module delayTimer
#(
   parameter int cycles = 16                   // delay length in clock cycles
)
(
   input  logic iClk,
   input  logic iRst_n,
   input  logic start,                         // hold high to run the delay
   output logic done                           // delay has expired
);

   localparam logic [`PSU_TIMER_W-1:0] lastCnt = `PSU_TIMER_W'(cycles); // count where done rises

   logic [`PSU_TIMER_W-1:0] count;             // cycles seen since start went high

   always_ff @(posedge iClk or negedge iRst_n)
   begin
      if (!iRst_n)
         count <= '0;
      else if (!start)
         count <= '0;                          // a dropped start restarts the delay
      else if (count != lastCnt)
         count <= count + 1'b1;                // stops at the end value
   end

   assign done = start && (count == lastCnt); // clears at once when start drops

endmodule

//--- common/psuSeqPkg.sv
/* power sequencer types
   sequencer state and rail fault code shared by the sequencer blocks */

package psuSeqPkg;

   //////////////////////////////////////////////////
   // sequencer state
   //////////////////////////////////////////////////
   typedef enum logic [3:0]
   {
      init   = 4'd0,                          // waiting for the master to enable the block
      s5     = 4'd1,                          // soft off, DIMM 12 V off
      s5p    = 4'd2,                          // soft off with DIMM 12 V kept on standby
      s3     = 4'd3,                          // suspend, DIMM 12 V from standby
      psu    = 4'd4,                          // PSU main 12 V enabled
      p5v    = 4'd5,                          // P5V main VR enabled
      s0hold = 4'd6,                          // running, DIMMs fed from standby and main
      s3hold = 4'd7,                          // going down, DIMMs fed from main and standby
      s0     = 4'd8,                          // running, DIMMs fed from main only
      s0down = 4'd9                           // main rails going down in order
   } psuState_e;

   //////////////////////////////////////////////////
   // fault code reported to the master
   //////////////////////////////////////////////////
   typedef enum logic [2:0]
   {
      none     = 3'd0,                        // no fault seen
      psuPwrOk = 3'd1,                        // PSU power good lost while ADR is off
      mainVr   = 3'd2                         // P3V3 main good lost while the PSU is good
   } faultCode_e;

endpackage

//--- common/psuSeq_settings.svh
/* power sequencer settings
   hand-over delays in clock cycles and the width of the delay counters */

`ifndef PSU_SEQ_SETTINGS_SVH
`define PSU_SEQ_SETTINGS_SVH

// standby to main hand-over of the DIMM 12 V switch
`define PSU_T1_CYCLES 1000

// main to standby hand-over of the DIMM 12 V switch
`define PSU_T2_CYCLES 400000

// counter width that holds the longest delay
`define PSU_TIMER_W 19

`endif
